// File: Makefile
VERILATOR ?= verilator
TOP       ?= fetch_stage_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
HEX       ?= verif/prog.hex
PASS_MSG  ?= all tests passed
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The ROM loads its image from the working directory
prog.hex: $(HEX)
	cp $(HEX) prog.hex

run: build prog.hex
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG) prog.hex

// File: design/bp_entry.sv
`default_nettype none

module bp_entry
    import fetch_pkg::*;
(
    input  logic      clk    ,
    input  logic      arst_n ,
    input  logic      we     ,
    input  bp_write_t wr     ,

    output bp_entry_t entry
);

    logic  valid_q;
    tag_t  tag_q;
    addr_t target_q;
    ctr_t  ctr_q;
    logic  match;

    assign match = valid_q && (tag_q == wr.tag);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
            ctr_q   <= '0;
        end else if (we) begin
            if (match) begin
                // Saturating counter
                if (wr.taken && ctr_q != 2'd3) begin
                    ctr_q <= ctr_q + 2'd1;
                end else if (!wr.taken && ctr_q != 2'd0) begin
                    ctr_q <= ctr_q - 2'd1;
                end
            end else if (wr.taken) begin
                valid_q <= 1'b1;
                ctr_q   <= CTR_ALLOC;
            end
        end
    end

    // Taken branch writes tag and target on allocate and on hit alike
    always_ff @(posedge clk) begin
        if (we && wr.taken) begin
            tag_q    <= wr.tag;
            target_q <= wr.target;
        end
    end

    assign entry.valid  = valid_q;
    assign entry.tag    = tag_q;
    assign entry.target = target_q;
    assign entry.ctr    = ctr_q;

endmodule

`default_nettype wire

// File: design/bp_lookup.sv
`default_nettype none

module bp_lookup
    import fetch_pkg::*;
(
    input  addr_t     pc                     ,
    input  inst_t     inst                   ,
    input  bp_entry_t entries [NUM_ENTRIES]  ,

    output logic      hit                    ,
    output logic      pred_taken             ,
    output addr_t     pred_target
);

    idx_t      idx;
    tag_t      tag;
    bp_entry_t sel;
    logic      tag_eq;
    logic      is_branch;

    assign idx = pc[IDX_W+1:2];
    assign tag = pc[31:IDX_W+2];
    assign sel = entries[idx];

    assign tag_eq    = sel.valid && (sel.tag == tag);
    // Only conditional branches are predicted
    assign is_branch = inst[6:0] == OPC_BRANCH;

    assign hit        = tag_eq & is_branch;
    assign pred_taken = hit & sel.ctr[1];

    // Target is only meaningful on a hit
    always_comb begin
        if (hit) begin
            pred_target = sel.target;
        end else begin
            pred_target = '0;
        end
    end

endmodule

`default_nettype wire

// File: design/bp_update.sv
`default_nettype none

module bp_update
    import fetch_pkg::*;
(
    input  bp_resolve_t            resolve     ,

    output logic [NUM_ENTRIES-1:0] entry_we    ,
    output bp_write_t              wr          ,
    output logic                   redirect    ,
    output addr_t                  redirect_pc
);

    idx_t idx;
    tag_t tag;
    logic dir_wrong;
    logic tgt_wrong;
    logic mispredict;

    // Index from bits 5:2 and tag from the bits above
    assign idx = resolve.pc[IDX_W+1:2];
    assign tag = resolve.pc[31:IDX_W+2];

    // One-hot strobe to the addressed entry
    always_comb begin
        entry_we      = '0;
        entry_we[idx] = resolve.valid;
    end

    // The same record goes to every entry and only the strobed one acts
    assign wr.tag    = tag;
    assign wr.taken  = resolve.taken;
    assign wr.target = resolve.target;

    assign dir_wrong  = resolve.taken != resolve.pred_taken;
    assign tgt_wrong  = resolve.taken && resolve.pred_taken &&
                        (resolve.target != resolve.pred_target);
    assign mispredict = dir_wrong | tgt_wrong;

    assign redirect = resolve.valid & mispredict;

    // Recover to the actual path
    always_comb begin
        if (resolve.taken) begin
            redirect_pc = resolve.target;
        end else begin
            redirect_pc = resolve.pc + 32'd4;
        end
    end

endmodule

`default_nettype wire

// File: design/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    localparam int NUM_ENTRIES = 16;
    localparam int IDX_W       = 4;
    localparam int TAG_W       = 26;
    localparam int ROM_WORDS   = 64;

    typedef logic [31:0]      addr_t;
    typedef logic [31:0]      inst_t;
    typedef logic [1:0]       ctr_t;
    typedef logic [IDX_W-1:0] idx_t;
    typedef logic [TAG_W-1:0] tag_t;

    localparam addr_t      RESET_PC   = 32'h0000_0000;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    // Weakly taken
    localparam ctr_t       CTR_ALLOC  = 2'd2;

    typedef struct packed {
        logic  valid;
        tag_t  tag;
        addr_t target;
        ctr_t  ctr;
    } bp_entry_t;

    // Resolution from a later stage, with the prediction carried along
    typedef struct packed {
        logic  valid;
        addr_t pc;
        logic  taken;
        addr_t target;
        logic  pred_taken;
        addr_t pred_target;
    } bp_resolve_t;

    typedef struct packed {
        tag_t  tag;
        logic  taken;
        addr_t target;
    } bp_write_t;

    typedef struct packed {
        addr_t pc;
        inst_t inst;
        addr_t pc_plus4;
        logic  pred_taken;
        addr_t pred_target;
        logic  hit;
    } fetch_out_t;

endpackage

`default_nettype wire

// File: design/fetch_stage.sv
`default_nettype none

module fetch_stage
    import fetch_pkg::*;
(
    input  logic        clk         ,
    input  logic        arst_n      ,
    input  logic        advance     ,
    input  bp_resolve_t resolve     ,

    output fetch_out_t  fetch       ,
    output logic        redirect    ,
    output addr_t       redirect_pc
);

    addr_t                  pc;
    addr_t                  pc_plus4;
    inst_t                  inst;
    logic                   hit;
    logic                   pred_taken;
    addr_t                  pred_target;
    logic [NUM_ENTRIES-1:0] entry_we;
    bp_write_t              wr;
    bp_entry_t              entries [NUM_ENTRIES];

    pc_gen pc_gen_i (
        .clk         (clk)         ,
        .arst_n      (arst_n)      ,
        .advance     (advance)     ,
        .redirect    (redirect)    ,
        .redirect_pc (redirect_pc) ,
        .pred_taken  (pred_taken)  ,
        .pred_target (pred_target) ,
        .pc          (pc)          ,
        .pc_plus4    (pc_plus4)
    );

    inst_rom inst_rom_i (
        .pc   (pc)   ,
        .inst (inst)
    );

    // Resolutions feed the table
    bp_update bp_update_i (
        .resolve     (resolve)     ,
        .entry_we    (entry_we)    ,
        .wr          (wr)          ,
        .redirect    (redirect)    ,
        .redirect_pc (redirect_pc)
    );

    for (genvar i = 0; i < NUM_ENTRIES; i++) begin : g_entry
        bp_entry bp_entry_i (
            .clk    (clk)         ,
            .arst_n (arst_n)      ,
            .we     (entry_we[i]) ,
            .wr     (wr)          ,
            .entry  (entries[i])
        );
    end

    // Fetch PC reads the table
    bp_lookup bp_lookup_i (
        .pc          (pc)          ,
        .inst        (inst)        ,
        .entries     (entries)     ,
        .hit         (hit)         ,
        .pred_taken  (pred_taken)  ,
        .pred_target (pred_target)
    );

    assign fetch = '{
        pc          : pc,
        inst        : inst,
        pc_plus4    : pc_plus4,
        pred_taken  : pred_taken,
        pred_target : pred_target,
        hit         : hit
    };

endmodule

`default_nettype wire

// File: design/inst_rom.sv
`default_nettype none

module inst_rom
    import fetch_pkg::*;
(
    input  addr_t pc   ,

    output inst_t inst
);

    inst_t mem [ROM_WORDS];

    // Words missing from the image read as zero
    initial begin
        for (int i = 0; i < ROM_WORDS; i++) begin
            mem[i] = '0;
        end
        $readmemh("prog.hex", mem);
    end

    // Word address from PC bits 7:2
    assign inst = mem[pc[7:2]];

endmodule

`default_nettype wire

// File: design/pc_gen.sv
`default_nettype none

module pc_gen
    import fetch_pkg::*;
(
    input  logic  clk         ,
    input  logic  arst_n      ,
    input  logic  advance     ,
    input  logic  redirect    ,
    input  addr_t redirect_pc ,
    input  logic  pred_taken  ,
    input  addr_t pred_target ,

    output addr_t pc          ,
    output addr_t pc_plus4
);

    addr_t next_pc;
    logic  load;

    assign pc_plus4 = pc + 32'd4;

    // Redirect wins over prediction and prediction over sequential
    always_comb begin
        if (redirect) begin
            next_pc = redirect_pc;
        end else if (pred_taken) begin
            next_pc = pred_target;
        end else begin
            next_pc = pc_plus4;
        end
    end

    // A redirect is taken even while stalled
    assign load = redirect | advance;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= RESET_PC;
        end else if (load) begin
            pc <= next_pc;
        end
    end

endmodule

`default_nettype wire

// File: sim.f
design/fetch_pkg.sv
design/pc_gen.sv
design/inst_rom.sv
design/bp_update.sv
design/bp_entry.sv
design/bp_lookup.sv
design/fetch_stage.sv
verif/fetch_stage_tb.sv

// File: verif/fetch_stage_tb.sv
`default_nettype none

module fetch_stage_tb
    import fetch_pkg::*;
();

    localparam logic [31:0] SEED            = 32'h4e70_3a81;
    localparam int          RANDOM_CYCLES   = 200;
    localparam int          DIRECTED_CYCLES = 200;
    localparam int          WATCHDOG_CYCLES = 5 * (RANDOM_CYCLES + DIRECTED_CYCLES);

    logic        clk = 1'b0;
    logic        arst_n;
    logic        advance;
    bp_resolve_t resolve;
    fetch_out_t  fetch;
    logic        redirect;
    addr_t       redirect_pc;

    // Reference copy of the program and of the predictor table
    inst_t       rom      [ROM_WORDS];
    logic        m_valid  [NUM_ENTRIES];
    tag_t        m_tag    [NUM_ENTRIES];
    addr_t       m_target [NUM_ENTRIES];
    ctr_t        m_ctr    [NUM_ENTRIES];
    addr_t       exp_pc;
    addr_t       pend_next;
    bp_resolve_t pend_res;
    addr_t       branch_pcs [6] = '{32'h08, 32'h20, 32'h34, 32'h48, 32'h5c, 32'h70};

    fetch_stage fetch_stage_i (
        .clk         (clk)         ,
        .arst_n      (arst_n)      ,
        .advance     (advance)     ,
        .resolve     (resolve)     ,
        .fetch       (fetch)       ,
        .redirect    (redirect)    ,
        .redirect_pc (redirect_pc)
    );

    always #4 clk = ~clk;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string test, input string what, input addr_t exp,
                              input addr_t act);
        assert (act === exp) else begin
            report_failure($sformatf("CHECK FAILED %s: %s expected %h actual %h",
                                     test, what, exp, act));
        end
    endtask

    task automatic check_flag(input string test, input string what, input logic exp,
                              input logic act);
        assert (act === exp) else begin
            report_failure($sformatf("CHECK FAILED %s: %s expected %b actual %b",
                                     test, what, exp, act));
        end
    endtask

    function automatic logic predicts_hit(input addr_t pc);
        idx_t i;
        i = pc[5:2];
        return m_valid[i] && (m_tag[i] == pc[31:6]) && (rom[pc[7:2]][6:0] == OPC_BRANCH);
    endfunction

    // Train on a tag match and allocate on a taken miss
    task automatic train_table(input addr_t pc, input logic taken, input addr_t target);
        idx_t i;
        i = pc[5:2];
        if (m_valid[i] && m_tag[i] == pc[31:6]) begin
            if (taken) begin
                if (m_ctr[i] != 2'd3) m_ctr[i] = m_ctr[i] + 2'd1;
                m_target[i] = target;
            end else if (m_ctr[i] != 2'd0) begin
                m_ctr[i] = m_ctr[i] - 2'd1;
            end
        end else if (taken) begin
            m_valid[i]  = 1'b1;
            m_tag[i]    = pc[31:6];
            m_target[i] = target;
            m_ctr[i]    = CTR_ALLOC;
        end
    endtask

    function automatic bp_resolve_t build_resolution(input addr_t pc, input logic taken,
            input addr_t target, input logic pred_taken, input addr_t pred_target);
        bp_resolve_t r;
        r.valid       = 1'b1;
        r.pc          = pc;
        r.taken       = taken;
        r.target      = target;
        r.pred_taken  = pred_taken;
        r.pred_target = pred_target;
        return r;
    endfunction

    // Each clock commits last cycle's effects, drives and checks the settled outputs
    task automatic run_cycle(input string test, input logic adv, input bp_resolve_t res);
        logic  exp_hit;
        logic  exp_pt;
        logic  exp_redir;
        addr_t exp_rpc;
        idx_t  i;
        @(posedge clk);
        if (pend_res.valid) train_table(pend_res.pc, pend_res.taken, pend_res.target);
        exp_pc = pend_next;
        @(negedge clk);
        advance = adv;
        resolve = res;
        #1;
        i         = exp_pc[5:2];
        exp_hit   = predicts_hit(exp_pc);
        exp_pt    = exp_hit && m_ctr[i][1];
        exp_redir = res.valid && ((res.taken != res.pred_taken) ||
                    (res.taken && res.pred_taken && res.target != res.pred_target));
        exp_rpc   = res.taken ? res.target : res.pc + 32'd4;
        check_word(test, "pc", exp_pc, fetch.pc);
        check_word(test, "inst", rom[exp_pc[7:2]], fetch.inst);
        check_word(test, "pc_plus4", exp_pc + 32'd4, fetch.pc_plus4);
        check_flag(test, "hit", exp_hit, fetch.hit);
        check_flag(test, "pred_taken", exp_pt, fetch.pred_taken);
        if (exp_hit) check_word(test, "pred_target", m_target[i], fetch.pred_target);
        check_flag(test, "redirect", exp_redir, redirect);
        if (exp_redir) check_word(test, "redirect_pc", exp_rpc, redirect_pc);
        if (exp_redir) pend_next = exp_rpc;
        else if (adv && exp_pt) pend_next = m_target[i];
        else if (adv) pend_next = exp_pc + 32'd4;
        else pend_next = exp_pc;
        pend_res = res;
    endtask

    // Not-taken resolution predicted taken sends the PC to its fall-through
    task automatic steer_to(input string test, input addr_t target);
        run_cycle(test, 1'b0, build_resolution(target - 32'd4, 1'b0, '0, 1'b1, '0));
        check_word(test, "steer redirect_pc", target, redirect_pc);
        run_cycle(test, 1'b0, '0);
        check_word(test, "steered pc", target, fetch.pc);
    endtask

    task automatic reset_and_sequential();
        string t = "reset_seq";
        for (int n = 0; n < 8; n++) begin
            run_cycle(t, 1'b1, '0);
            check_word(t, "sequential pc", 32'(n * 4), fetch.pc);
            check_flag(t, "cold hit", 1'b0, fetch.hit);
        end
    endtask

    task automatic stall_and_redirect();
        string t = "stall";
        run_cycle(t, 1'b0, '0);
        check_word(t, "pc at stall", 32'h20, fetch.pc);
        repeat (3) begin
            run_cycle(t, 1'b0, '0);
            check_word(t, "held pc", 32'h20, fetch.pc);
            check_word(t, "held inst", rom[8], fetch.inst);
        end
        run_cycle(t, 1'b0, build_resolution(32'h2c, 1'b0, '0, 1'b1, '0));
        check_flag(t, "stalled redirect", 1'b1, redirect);
        check_word(t, "stalled redirect_pc", 32'h30, redirect_pc);
        run_cycle(t, 1'b0, '0);
        check_word(t, "pc after stalled redirect", 32'h30, fetch.pc);
    endtask

    task automatic cold_allocation();
        string t = "cold_alloc";
        run_cycle(t, 1'b0, build_resolution(32'h08, 1'b1, 32'h40, 1'b0, '0));
        check_flag(t, "cold redirect", 1'b1, redirect);
        check_word(t, "cold redirect_pc", 32'h40, redirect_pc);
        run_cycle(t, 1'b0, '0);
        check_word(t, "pc at target", 32'h40, fetch.pc);
        steer_to(t, 32'h08);
        run_cycle(t, 1'b1, '0);
        check_flag(t, "allocated hit", 1'b1, fetch.hit);
        check_flag(t, "allocated pred_taken", 1'b1, fetch.pred_taken);
        check_word(t, "allocated pred_target", 32'h40, fetch.pred_target);
        run_cycle(t, 1'b0, '0);
        check_word(t, "pc after prediction", 32'h40, fetch.pc);
    endtask

    task automatic counter_training();
        string t = "training";
        run_cycle(t, 1'b0, build_resolution(32'h08, 1'b0, '0, 1'b1, 32'h40));
        check_word(t, "not-taken redirect_pc", 32'h0c, redirect_pc);
        steer_to(t, 32'h08);
        check_flag(t, "weak not-taken hit", 1'b1, fetch.hit);
        check_flag(t, "weak not-taken pred", 1'b0, fetch.pred_taken);
        run_cycle(t, 1'b0, build_resolution(32'h08, 1'b1, 32'h40, 1'b0, '0));
        run_cycle(t, 1'b0, build_resolution(32'h08, 1'b1, 32'h40, 1'b1, 32'h40));
        check_flag(t, "correct taken redirect", 1'b0, redirect);
        steer_to(t, 32'h08);
        check_flag(t, "retrained pred", 1'b1, fetch.pred_taken);
        run_cycle(t, 1'b0, build_resolution(32'h08, 1'b1, 32'h40, 1'b1, 32'h40));
        run_cycle(t, 1'b0, build_resolution(32'h08, 1'b0, '0, 1'b1, 32'h40));
        steer_to(t, 32'h08);
        check_flag(t, "saturated pred", 1'b1, fetch.pred_taken);
    endtask

    task automatic tag_and_opcode();
        string t = "tag_opcode";
        steer_to(t, 32'h48);
        check_flag(t, "other tag hit", 1'b0, fetch.hit);
        run_cycle(t, 1'b0, build_resolution(32'h28, 1'b1, 32'h60, 1'b0, '0));
        steer_to(t, 32'h28);
        check_flag(t, "non-branch hit", 1'b0, fetch.hit);
        run_cycle(t, 1'b0, build_resolution(32'h34, 1'b0, '0, 1'b0, '0));
        check_flag(t, "correct not-taken redirect", 1'b0, redirect);
        steer_to(t, 32'h34);
        check_flag(t, "not-taken allocation hit", 1'b0, fetch.hit);
        run_cycle(t, 1'b0, build_resolution(32'h08, 1'b1, 32'h40, 1'b1, 32'h40));
        check_flag(t, "correct prediction redirect", 1'b0, redirect);
        run_cycle(t, 1'b0, build_resolution(32'h08, 1'b1, 32'h40, 1'b1, 32'h44));
        check_word(t, "wrong target redirect_pc", 32'h40, redirect_pc);
    endtask

    task automatic random_mix();
        string       t = "random";
        logic [31:0] r;
        logic [2:0]  sel;
        addr_t       bpc;
        bp_resolve_t res;
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            r   = $urandom();
            sel = r[4:2] % 3'd6;
            bpc = branch_pcs[sel];
            // Prediction as the table model stood before this cycle's pending write
            res = build_resolution(bpc, r[1], {25'd0, r[9:5], 2'b00},
                                   predicts_hit(bpc) && m_ctr[bpc[5:2]][1],
                                   predicts_hit(bpc) ? m_target[bpc[5:2]] : '0);
            res.valid = r[0];
            run_cycle(t, r[10], res);
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        report_failure("Timeout: the tests did not finish within the cycle budget");
    end

    initial begin
        void'($urandom(SEED));
        arst_n    = 1'b0;
        advance   = 1'b0;
        resolve   = '0;
        exp_pc    = RESET_PC;
        pend_next = RESET_PC;
        pend_res  = '0;
        for (int i = 0; i < ROM_WORDS; i++) rom[i] = '0;
        $readmemh("verif/prog.hex", rom);
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            m_valid[i]  = 1'b0;
            m_tag[i]    = '0;
            m_target[i] = '0;
            m_ctr[i]    = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        reset_and_sequential();
        stall_and_redirect();
        cold_allocation();
        counter_training();
        tag_and_opcode();
        random_mix();
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/prog.hex
// Program image, two 32-bit words per line from address 0x00 upward
// Conditional branches at 0x08, 0x20, 0x34, 0x48, 0x5c and 0x70
00100093 00200113
00208463 00000013
002081b3 0000a103
0020a023 00000013
fe209ee3 00100093
00000013 002081b3
0000a103 00c5d663
00000013 0020a023
00100093 00200113
00208463 00000013
002081b3 0000a103
0020a023 fe209ee3
00000013 00100093
002081b3 00000013
00c5d663 0000a103
0020a023 00000013
